/* tb.f */
+incdir+common
common/mem_stage_pkg.sv
rtl/ex_mem_latch.sv
mm/mem_access_align.sv
mm/data_ram.sv
rtl/mem_wb_latch.sv
rtl/mem_stage_top.sv
bench/mem_stage_assert.sv
bench/mem_stage_tb.sv

/* Bender.yml */
package:
  name: mem_stage

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mem_stage_pkg.sv
      - rtl/ex_mem_latch.sv
      - mm/mem_access_align.sv
      - mm/data_ram.sv
      - rtl/mem_wb_latch.sv
      - rtl/mem_stage_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/mem_stage_assert.sv
      - bench/mem_stage_tb.sv

/* bench/mem_stage_tb.sv */
`timescale 1ns/10ps

`include "mem_stage_consts.svh"

module mem_stage_tb import mem_stage_pkg::*; ();

    logic                   clk_i;
    logic                   rst_n_i;
    logic                   valid_i;
    access_op_e             op_i;
    access_sz_e             sz_i;
    logic                   unsigned_i;
    logic [`DATA_W-1:0]     addr_i;
    logic [`DATA_W-1:0]     wdata_i;
    logic [`REG_ADDR_W-1:0] reg_addr_i;
    logic                   valid_o;
    logic                   wb_en_o;
    logic [`DATA_W-1:0]     wb_data_o;
    logic [`REG_ADDR_W-1:0] wb_reg_addr_o;
    logic                   fault_o;

    integer seed      = 96;
    int     errors    = 0;
    string  test_name = "reset";

    // Big-endian model of the 64-word window, offset 0 in bits 31..24.
    logic [`DATA_W-1:0] shadow [0:63];

    logic [`DATA_W-1:0]     exp_data_q [$];
    logic [`REG_ADDR_W-1:0] exp_reg_q [$];
    logic                   exp_en_q [$];
    logic                   exp_fault_q [$];
    string                  exp_name_q [$];

    mem_stage_top uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ==========================================================
    // Checking and prediction
    // ==========================================================

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_idle();
        check_value({test_name, " valid_o"}, 32'd0, {31'd0, valid_o});
        check_value({test_name, " wb_en_o"}, 32'd0, {31'd0, wb_en_o});
        check_value({test_name, " fault_o"}, 32'd0, {31'd0, fault_o});
    endtask

    task automatic predict(input access_op_e op, input access_sz_e sz, input logic uns,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           output logic [31:0] data, output logic en, output logic flt);
        logic       mis;
        logic [7:0] b;
        logic [15:0] h;
        int         off;
        int         idx;
        off  = addr[1:0];
        idx  = addr[7:2];
        mis  = (op != OP_D2R) &&
               ((sz == SZ_HALF && addr[0]) || (sz == SZ_WORD && addr[1:0] != 2'b00));
        data = wdata;
        en   = (op == OP_D2R) || (op == OP_M2R && !mis);
        flt  = mis;
        if (op == OP_M2R && !mis) begin
            b = shadow[idx][31-8*off -: 8];
            h = shadow[idx][31-8*off -: 16];
            case (sz)
                SZ_BYTE: data = uns ? {24'd0, b} : {{24{b[7]}}, b};
                SZ_HALF: data = uns ? {16'd0, h} : {{16{h[15]}}, h};
                default: data = shadow[idx];
            endcase
        end
        if (op == OP_R2M && !mis) begin
            case (sz)
                SZ_BYTE: shadow[idx][31-8*off -: 8] = wdata[7:0];
                SZ_HALF: shadow[idx][31-8*off -: 16] = wdata[15:0];
                default: shadow[idx] = wdata;
            endcase
        end
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [31:0] rand_base();
        return ({$random(seed)} % 64) * 4;
    endfunction

    // Drives one operation for one cycle and queues its result.
    task automatic issue(input access_op_e op, input access_sz_e sz, input logic uns,
                         input logic [31:0] addr, input logic [31:0] wdata);
        logic [31:0] data;
        logic        en;
        logic        flt;
        logic [31:0] rnd;
        logic [4:0]  reg_a;
        rnd   = rand_word();
        reg_a = rnd[4:0];
        predict(op, sz, uns, addr, wdata, data, en, flt);
        valid_i    = 1'b1;
        op_i       = op;
        sz_i       = sz;
        unsigned_i = uns;
        addr_i     = addr;
        wdata_i    = wdata;
        reg_addr_i = reg_a;
        exp_data_q.push_back(data);
        exp_reg_q.push_back(reg_a);
        exp_en_q.push_back(en);
        exp_fault_q.push_back(flt);
        exp_name_q.push_back(test_name);
        @(negedge clk_i);
    endtask

    task automatic compare_result();
        string       name;
        logic [31:0] e_data;
        logic [4:0]  e_reg;
        logic        e_en;
        logic        e_flt;
        name   = exp_name_q.pop_front();
        e_data = exp_data_q.pop_front();
        e_reg  = exp_reg_q.pop_front();
        e_en   = exp_en_q.pop_front();
        e_flt  = exp_fault_q.pop_front();
        check_value({name, " wb_en_o"}, {31'd0, e_en}, {31'd0, wb_en_o});
        check_value({name, " fault_o"}, {31'd0, e_flt}, {31'd0, fault_o});
        check_value({name, " wb_reg_addr_o"}, {27'd0, e_reg}, {27'd0, wb_reg_addr_o});
        // A faulting load returns no defined data.
        if (!e_flt) begin
            check_value({name, " wb_data_o"}, e_data, wb_data_o);
        end
    endtask

    // Outputs are registered, so they are stable at the falling edge.
    always @(negedge clk_i) begin
        if (rst_n_i === 1'b1 && valid_o === 1'b1) begin
            if (exp_data_q.size() == 0) begin
                errors++;
                $display("Result appeared with no operation outstanding");
            end else begin
                compare_result();
            end
        end
    end

    // ==========================================================
    // Stimulus
    // ==========================================================

    initial begin
        logic [31:0] base;
        logic [31:0] data;
        int          off;
        int          i;
        rst_n_i    = 1'b0;
        valid_i    = 1'b0;
        op_i       = OP_D2R;
        sz_i       = SZ_WORD;
        unsigned_i = 1'b0;
        addr_i     = '0;
        wdata_i    = '0;
        reg_addr_i = '0;
        repeat (16) begin
            @(negedge clk_i);
            check_idle();
        end
        rst_n_i = 1'b1;
        @(negedge clk_i);
        check_idle();

        test_name = "prefill";
        for (i = 0; i < 64; i++) begin
            issue(OP_R2M, SZ_WORD, 1'b0, i * 4, rand_word());
        end

        test_name = "store_load";
        repeat (8) begin
            base = rand_base();
            data = rand_word();
            issue(OP_R2M, SZ_WORD, 1'b0, base, data);
            issue(OP_M2R, SZ_WORD, 1'b0, base, '0);
        end

        test_name = "merge";
        repeat (4) begin
            base = rand_base();
            for (off = 0; off < 4; off++) begin
                issue(OP_R2M, SZ_BYTE, 1'b0, base + off, rand_word());
            end
            issue(OP_M2R, SZ_WORD, 1'b0, base, '0);
            issue(OP_R2M, SZ_HALF, 1'b0, base, rand_word());
            issue(OP_R2M, SZ_HALF, 1'b0, base + 2, rand_word());
            issue(OP_M2R, SZ_WORD, 1'b0, base, '0);
        end

        test_name = "extend";
        repeat (4) begin
            base = rand_base();
            issue(OP_R2M, SZ_WORD, 1'b0, base, rand_word() | 32'h8080_8080);
            for (off = 0; off < 4; off++) begin
                issue(OP_M2R, SZ_BYTE, 1'b0, base + off, '0);
                issue(OP_M2R, SZ_BYTE, 1'b1, base + off, '0);
            end
            for (off = 0; off < 4; off += 2) begin
                issue(OP_M2R, SZ_HALF, 1'b0, base + off, '0);
                issue(OP_M2R, SZ_HALF, 1'b1, base + off, '0);
            end
        end

        // Pass-through ignores the address, so unaligned ones must not fault.
        test_name = "pass";
        for (i = 0; i < 8; i++) begin
            issue(OP_D2R, SZ_WORD, 1'b0, rand_base() + (i % 4), rand_word());
        end

        test_name = "misaligned";
        repeat (4) begin
            base = rand_base();
            issue(OP_R2M, SZ_HALF, 1'b0, base + 1, rand_word());
            issue(OP_R2M, SZ_HALF, 1'b0, base + 3, rand_word());
            for (off = 1; off < 4; off++) begin
                issue(OP_R2M, SZ_WORD, 1'b0, base + off, rand_word());
            end
            issue(OP_M2R, SZ_HALF, 1'b0, base + 1, '0);
            issue(OP_M2R, SZ_WORD, 1'b0, base + 2, '0);
            issue(OP_M2R, SZ_WORD, 1'b0, base, '0);
        end
        valid_i = 1'b0;

        for (i = 0; i < 100 && exp_data_q.size() > 0; i++) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        $display("errors: %0d compare, %0d assertion", errors, uut.u_assert.fail_count);
        if (exp_data_q.size() > 0) begin
            $display("Timed out waiting for %0d outstanding results", exp_data_q.size());
            $display("test failed");
        end else if (errors == 0 && uut.u_assert.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* bench/mem_stage_assert.sv */
`timescale 1ns/10ps

module mem_stage_assert (
    input logic clk_i,
    input logic rst_n_i,
    input logic valid_i,
    input logic out_valid_i,
    input logic wb_en_i,
    input logic fault_i,
    input logic mem_wr_i,
    input logic misaligned_i
);

    int fail_count = 0;

    // ==========================================================
    // Pipeline timing
    // ==========================================================

    // An operation sampled at edge N is presented after edge N+1.
    valid_latency: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        out_valid_i == $past(valid_i, 2)
    ) else begin
        fail_count++;
        $error("valid_o does not follow valid_i by two edges");
    end

    // ==========================================================
    // Fault handling
    // ==========================================================

    // A faulting access never writes the register file.
    wb_fault_exclusive: assert property (
        @(posedge clk_i) !(wb_en_i && fault_i)
    ) else begin
        fail_count++;
        $error("wb_en_o and fault_o are high together");
    end

    // The RAM must be left untouched by a misaligned store.
    no_misaligned_write: assert property (
        @(posedge clk_i) !(mem_wr_i && misaligned_i)
    ) else begin
        fail_count++;
        $error("RAM write enabled for a misaligned access");
    end

    // ==========================================================
    // Reset
    // ==========================================================

    reset_quiet: assert property (
        @(posedge clk_i) !rst_n_i |-> (!out_valid_i && !wb_en_i && !fault_i)
    ) else begin
        fail_count++;
        $error("control outputs not low during reset");
    end

endmodule

bind mem_stage_top mem_stage_assert u_assert (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .valid_i      (valid_i),
    .out_valid_i  (valid_o),
    .wb_en_i      (wb_en_o),
    .fault_i      (fault_o),
    .mem_wr_i     (mem_wr),
    .misaligned_i (misaligned)
);

/* rtl/mem_stage_top.sv */
`timescale 1ns/10ps

`include "mem_stage_consts.svh"

module mem_stage_top import mem_stage_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   valid_i,
    input  access_op_e             op_i,
    input  access_sz_e             sz_i,
    input  logic                   unsigned_i,
    input  logic [`DATA_W-1:0]     addr_i,
    input  logic [`DATA_W-1:0]     wdata_i,
    input  logic [`REG_ADDR_W-1:0] reg_addr_i,
    output logic                   valid_o,
    output logic                   wb_en_o,
    output logic [`DATA_W-1:0]     wb_data_o,
    output logic [`REG_ADDR_W-1:0] wb_reg_addr_o,
    output logic                   fault_o
);

    logic                   ex_valid;
    access_op_e             ex_op;
    access_sz_e             ex_sz;
    logic                   ex_unsigned;
    logic [`DATA_W-1:0]     ex_addr;
    logic [`DATA_W-1:0]     ex_wdata;
    logic [`REG_ADDR_W-1:0] ex_reg_addr;

    logic [`DATA_W-1:0]     mem_address;
    logic                   mem_wr;
    logic [3:0]             mem_byte_en;
    logic [`DATA_W-1:0]     mem_wdata;
    logic [`DATA_W-1:0]     mem_rdata;
    logic [`DATA_W-1:0]     align_data;
    logic                   misaligned;

    ex_mem_latch u_ex_mem (
        .clk_i, .rst_n_i, .valid_i, .op_i, .sz_i, .unsigned_i,
        .addr_i, .wdata_i, .reg_addr_i,
        .valid_o    (ex_valid),
        .op_o       (ex_op),
        .sz_o       (ex_sz),
        .unsigned_o (ex_unsigned),
        .addr_o     (ex_addr),
        .wdata_o    (ex_wdata),
        .reg_addr_o (ex_reg_addr)
    );

    mem_access_align u_align (
        .valid_i       (ex_valid),
        .op_i          (ex_op),
        .sz_i          (ex_sz),
        .unsigned_i    (ex_unsigned),
        .addr_i        (ex_addr),
        .wdata_i       (ex_wdata),
        .mem_data_i    (mem_rdata),
        .mem_address_o (mem_address),
        .mem_wr_o      (mem_wr),
        .mem_byte_en_o (mem_byte_en),
        .mem_data_o    (mem_wdata),
        .data_o        (align_data),
        .misaligned_o  (misaligned)
    );

    // The RAM is word organized, so the byte offset bits are dropped.
    data_ram u_ram (
        .clk_i,
        .addr_i    (mem_address[`RAM_AW+1:2]),
        .wr_i      (mem_wr),
        .byte_en_i (mem_byte_en),
        .wdata_i   (mem_wdata),
        .rdata_o   (mem_rdata)
    );

    mem_wb_latch u_mem_wb (
        .clk_i, .rst_n_i,
        .valid_i      (ex_valid),
        .op_i         (ex_op),
        .reg_addr_i   (ex_reg_addr),
        .data_i       (align_data),
        .misaligned_i (misaligned),
        .valid_o, .wb_en_o, .wb_data_o, .wb_reg_addr_o, .fault_o
    );

endmodule

/* rtl/mem_wb_latch.sv */
`timescale 1ns/10ps

`include "mem_stage_consts.svh"

module mem_wb_latch import mem_stage_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   valid_i,
    input  access_op_e             op_i,
    input  logic [`REG_ADDR_W-1:0] reg_addr_i,
    input  logic [`DATA_W-1:0]     data_i,
    input  logic                   misaligned_i,
    output logic                   valid_o,
    output logic                   wb_en_o,
    output logic [`DATA_W-1:0]     wb_data_o,
    output logic [`REG_ADDR_W-1:0] wb_reg_addr_o,
    output logic                   fault_o
);

    logic writes_reg;

    // Stores produce no register result.
    assign writes_reg = (op_i == OP_D2R) || (op_i == OP_M2R);

    // ==========================================================
    // Write-back control
    // ==========================================================

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            wb_en_o <= 1'b0;
            fault_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
            wb_en_o <= valid_i & writes_reg & ~misaligned_i;
            fault_o <= valid_i & misaligned_i;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_data_o     <= data_i;
        wb_reg_addr_o <= reg_addr_i;
    end

endmodule

/* mm/data_ram.sv */
`timescale 1ns/10ps

`include "mem_stage_consts.svh"

module data_ram (
    input  logic               clk_i,
    input  logic [`RAM_AW-1:0] addr_i,
    input  logic               wr_i,
    input  logic [3:0]         byte_en_i,
    input  logic [`DATA_W-1:0] wdata_i,
    output logic [`DATA_W-1:0] rdata_o
);

    // ==========================================================
    // Storage array
    // ==========================================================

    logic [`DATA_W-1:0] mem [0:(1<<`RAM_AW)-1];

    // Read is combinational, so a load in the cycle after a store
    // to the same word sees the new contents.
    assign rdata_o = mem[addr_i];

    // Byte enable bit 3 covers bits 31..24, which is byte offset 0.
    always_ff @(posedge clk_i) begin
        if (wr_i) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en_i[b]) begin
                    mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule

/* mm/mem_access_align.sv */
`timescale 1ns/10ps

`include "mem_stage_consts.svh"

module mem_access_align import mem_stage_pkg::*; (
    input  logic               valid_i,
    input  access_op_e         op_i,
    input  access_sz_e         sz_i,
    input  logic               unsigned_i,
    input  logic [`DATA_W-1:0] addr_i,
    input  logic [`DATA_W-1:0] wdata_i,
    input  logic [`DATA_W-1:0] mem_data_i,
    output logic [`DATA_W-1:0] mem_address_o,
    output logic               mem_wr_o,
    output logic [3:0]         mem_byte_en_o,
    output logic [`DATA_W-1:0] mem_data_o,
    output logic [`DATA_W-1:0] data_o,
    output logic               misaligned_o
);

    logic        mem_op;
    logic [15:0] half_lane;
    logic [7:0]  byte_lane;

    assign mem_address_o = {addr_i[`DATA_W-1:2], 2'b00};
    assign mem_op        = (op_i == OP_M2R) || (op_i == OP_R2M);

    // Only memory operations can fault; a pass-through carries no address.
    always_comb begin
        case (sz_i)
            SZ_HALF: misaligned_o = mem_op & addr_i[0];
            SZ_BYTE: misaligned_o = 1'b0;
            default: misaligned_o = mem_op & (addr_i[1:0] != 2'b00);
        endcase
    end

    // ==========================================================
    // Big-endian lane selection
    // ==========================================================

    // Offset 0 is the most significant byte of the word.
    always_comb begin
        half_lane = addr_i[1] ? mem_data_i[15:0] : mem_data_i[31:16];
        case (addr_i[1:0])
            2'b00:   byte_lane = mem_data_i[31:24];
            2'b01:   byte_lane = mem_data_i[23:16];
            2'b10:   byte_lane = mem_data_i[15:8];
            default: byte_lane = mem_data_i[7:0];
        endcase
    end

    always_comb begin
        case (sz_i)
            SZ_HALF: mem_byte_en_o = addr_i[1] ? 4'b0011 : 4'b1100;
            SZ_BYTE: mem_byte_en_o = 4'b1000 >> addr_i[1:0];
            default: mem_byte_en_o = 4'b1111;
        endcase
    end

    // ==========================================================
    // Load extension and store replication
    // ==========================================================

    always_comb begin
        mem_wr_o   = 1'b0;
        mem_data_o = '0;
        data_o     = wdata_i;
        case (op_i)
            OP_M2R: begin
                case (sz_i)
                    SZ_HALF: data_o = unsigned_i ? {{(`DATA_W-16){1'b0}}, half_lane}
                                                 : {{(`DATA_W-16){half_lane[15]}}, half_lane};
                    SZ_BYTE: data_o = unsigned_i ? {{(`DATA_W-8){1'b0}}, byte_lane}
                                                 : {{(`DATA_W-8){byte_lane[7]}}, byte_lane};
                    default: data_o = mem_data_i;
                endcase
            end
            OP_R2M: begin
                // The byte enables pick the lane, so every lane gets a copy.
                mem_wr_o = valid_i & ~misaligned_o;
                case (sz_i)
                    SZ_HALF: mem_data_o = {2{wdata_i[15:0]}};
                    SZ_BYTE: mem_data_o = {4{wdata_i[7:0]}};
                    default: mem_data_o = wdata_i;
                endcase
            end
            default: begin
                data_o = wdata_i;
            end
        endcase
    end

endmodule

/* rtl/ex_mem_latch.sv */
`timescale 1ns/10ps

`include "mem_stage_consts.svh"

module ex_mem_latch import mem_stage_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   valid_i,
    input  access_op_e             op_i,
    input  access_sz_e             sz_i,
    input  logic                   unsigned_i,
    input  logic [`DATA_W-1:0]     addr_i,
    input  logic [`DATA_W-1:0]     wdata_i,
    input  logic [`REG_ADDR_W-1:0] reg_addr_i,
    output logic                   valid_o,
    output access_op_e             op_o,
    output access_sz_e             sz_o,
    output logic                   unsigned_o,
    output logic [`DATA_W-1:0]     addr_o,
    output logic [`DATA_W-1:0]     wdata_o,
    output logic [`REG_ADDR_W-1:0] reg_addr_o
);

    // ==========================================================
    // Control fields
    // ==========================================================

    // An empty slot is turned into a pass-through, so it can
    // never reach the RAM write port.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            op_o    <= OP_D2R;
        end else begin
            valid_o <= valid_i;
            op_o    <= valid_i ? op_i : OP_D2R;
        end
    end

    // ==========================================================
    // Operation payload
    // ==========================================================

    always_ff @(posedge clk_i) begin
        sz_o       <= sz_i;
        unsigned_o <= unsigned_i;
        addr_o     <= addr_i;
        wdata_o    <= wdata_i;
        reg_addr_o <= reg_addr_i;
    end

endmodule

/* common/mem_stage_pkg.sv */
package mem_stage_pkg;

    // ==========================================================
    // Memory stage operation
    // ==========================================================

    // D2R passes the register value straight to write-back,
    // M2R loads from memory and R2M stores to memory.
    typedef enum logic [1:0] {
        OP_D2R = 2'd0,
        OP_M2R = 2'd1,
        OP_R2M = 2'd2
    } access_op_e;

    // ==========================================================
    // Access width
    // ==========================================================

    // Half and word accesses must sit on their natural boundary.
    typedef enum logic [1:0] {
        SZ_WORD = 2'd0,
        SZ_HALF = 2'd1,
        SZ_BYTE = 2'd2
    } access_sz_e;

endpackage

/* common/mem_stage_consts.svh */
`ifndef MEM_STAGE_CONSTS_SVH
`define MEM_STAGE_CONSTS_SVH

// Data path and byte address width.
`define DATA_W 32

// Register file index width, 32 registers.
`define REG_ADDR_W 5

// Word address width of the data RAM.
`define RAM_AW 10

`endif
